// ==== source/stopwatch_pkg.sv ====
package stopwatch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Digit and time layout
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_DIGITS  = 4;  // 0 minutes, 1 tens of sec, 2 sec, 3 tenths
  localparam int DIGIT_WIDTH = 4;

  typedef logic [DIGIT_WIDTH-1:0] digit_t;
  typedef digit_t [NUM_DIGITS-1:0] time_t;

  // Highest value per digit, index 0 on the right
  localparam time_t digit_limit = {digit_t'(9), digit_t'(9), digit_t'(5), digit_t'(9)};

  //////////////////////////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////////////////////////

  localparam int TICK_DIVIDE = 10;  // Enabled cycles per tenth, small for sim
  localparam int TICK_WIDTH  = $clog2(TICK_DIVIDE);
  localparam int SYNC_STAGES = 2;

  //////////////////////////////////////////////////////////////////////
  // Display
  //////////////////////////////////////////////////////////////////////

  localparam int SEG_WIDTH   = 7;
  localparam int SEG_ENTRIES = 10;
  localparam int SCAN_WIDTH  = 2;

  typedef logic [SEG_WIDTH-1:0] seg_t;     // Active low, bit 0 = a .. bit 6 = g
  typedef logic [NUM_DIGITS-1:0] anode_t;  // Active low

  // Entry 0 is the rightmost element
  localparam seg_t [SEG_ENTRIES-1:0] SEG_TABLE = {
    seg_t'(7'h10),  // 9
    seg_t'(7'h00),  // 8
    seg_t'(7'h78),  // 7
    seg_t'(7'h02),  // 6
    seg_t'(7'h12),  // 5
    seg_t'(7'h19),  // 4
    seg_t'(7'h30),  // 3
    seg_t'(7'h24),  // 2
    seg_t'(7'h79),  // 1
    seg_t'(7'h40)   // 0
  };

  localparam seg_t   SEG_BLANK  = '1;
  localparam anode_t ANODE_IDLE = '1;

endpackage

// ==== source/mode_decode.sv ====
`timescale 1ns/1ps

module mode_decode (
  input  logic clock,
  input  logic rst,
  input  logic up,
  output logic down_mode,
  output logic load_down
);

  //////////////////////////////////////////////////////////////////////
  // Switch synchroniser
  //////////////////////////////////////////////////////////////////////

  logic [stopwatch_pkg::SYNC_STAGES-1:0] up_sync;  // Stage 0 samples the pin
  logic                                  mode_prev;

  always_ff @(posedge clock) begin
    if (rst) begin
      up_sync   <= '0;
      mode_prev <= 1'b0;
    end else begin
      up_sync   <= {up_sync[stopwatch_pkg::SYNC_STAGES-2:0], up};
      mode_prev <= down_mode;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Mode level and rising edge
  //////////////////////////////////////////////////////////////////////

  assign down_mode = up_sync[stopwatch_pkg::SYNC_STAGES-1];

  // One cycle, lined up with the first high cycle of down_mode
  assign load_down = down_mode & ~mode_prev;

endmodule

// ==== source/tenth_tick_gen.sv ====
`timescale 1ns/1ps

module tenth_tick_gen (
  input  logic clock,
  input  logic rst,
  input  logic clr,
  input  logic enable,
  output logic tick
);

  localparam logic [stopwatch_pkg::TICK_WIDTH-1:0] LAST_COUNT =
    stopwatch_pkg::TICK_WIDTH'(stopwatch_pkg::TICK_DIVIDE - 1);

  logic [stopwatch_pkg::TICK_WIDTH-1:0] count;
  logic                                 terminal;

  assign terminal = (count == LAST_COUNT);

  always_ff @(posedge clock) begin
    if (rst || clr) begin
      count <= '0;
    end else if (enable) begin
      if (terminal) count <= '0;  // Wrap on the tick cycle
      else          count <= count + 1'b1;
    end
  end

  // Only counts as a tick when the cycle itself is enabled
  assign tick = enable & terminal;

endmodule

// ==== source/stopwatch_core.sv ====
`timescale 1ns/1ps

module stopwatch_core (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 clr,
  input  logic                 tick,
  input  logic                 load_down,
  output stopwatch_pkg::time_t up_time,
  output stopwatch_pkg::time_t down_time
);

  localparam int LSD = stopwatch_pkg::NUM_DIGITS - 1;  // Tenths digit

  // Ripple into each digit, entry i feeds digit i
  logic [stopwatch_pkg::NUM_DIGITS-1:0] carry_in;
  logic [stopwatch_pkg::NUM_DIGITS-1:0] borrow_in;

  stopwatch_pkg::time_t up_next;
  stopwatch_pkg::time_t down_next;

  //////////////////////////////////////////////////////////////////////
  // Per digit next values
  //////////////////////////////////////////////////////////////////////

  assign carry_in[LSD]  = tick;
  assign borrow_in[LSD] = tick;

  genvar i;

  generate
    for (i = 0; i < stopwatch_pkg::NUM_DIGITS; i = i + 1) begin : g_digit
      logic at_limit;
      logic at_zero;

      assign at_limit = (up_time[i] == stopwatch_pkg::digit_limit[i]);
      assign at_zero  = (down_time[i] == '0);

      // Up side, wrap to 0 past the limit
      always_comb begin
        if (!carry_in[i])  up_next[i] = up_time[i];
        else if (at_limit) up_next[i] = '0;
        else               up_next[i] = up_time[i] + 1'b1;
      end

      // Down side, 0 goes back to the limit
      always_comb begin
        if (!borrow_in[i]) down_next[i] = down_time[i];
        else if (at_zero)  down_next[i] = stopwatch_pkg::digit_limit[i];
        else               down_next[i] = down_time[i] - 1'b1;
      end

      // Pass the ripple on to the next more significant digit.
      // The minutes digit drops it, so 9:59.9 and 0:00.0 wrap round.
      if (i > 0) begin : g_ripple
        assign carry_in[i-1]  = carry_in[i] & at_limit;
        assign borrow_in[i-1] = borrow_in[i] & at_zero;
      end
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Chain registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst || clr) begin
      up_time <= '0;
    end else if (tick) begin
      up_time <= up_next;
    end
  end

  always_ff @(posedge clock) begin
    if (rst || clr) begin
      down_time <= '0;
    end else if (load_down) begin
      down_time <= up_time;  // Snapshot beats a tick in the same cycle
    end else if (tick) begin
      down_time <= down_next;
    end
  end

endmodule

// ==== source/display_scan.sv ====
`timescale 1ns/1ps

module display_scan (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  down_mode,
  input  stopwatch_pkg::time_t  up_time,
  input  stopwatch_pkg::time_t  down_time,
  output stopwatch_pkg::anode_t anode,
  output stopwatch_pkg::seg_t   segment
);

  logic [stopwatch_pkg::SCAN_WIDTH-1:0] scan_idx;

  stopwatch_pkg::time_t  shown_time;
  stopwatch_pkg::digit_t shown_digit;
  stopwatch_pkg::seg_t   seg_next;
  stopwatch_pkg::anode_t anode_next;
  stopwatch_pkg::anode_t anode_hot;

  //////////////////////////////////////////////////////////////////////
  // Scan index, free running
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) scan_idx <= '0;
    else     scan_idx <= scan_idx + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Chain and digit select, segment lookup
  //////////////////////////////////////////////////////////////////////

  assign shown_time  = down_mode ? down_time : up_time;
  assign shown_digit = shown_time[scan_idx];

  always_comb begin
    if (shown_digit < stopwatch_pkg::digit_t'(stopwatch_pkg::SEG_ENTRIES)) begin
      seg_next = stopwatch_pkg::SEG_TABLE[shown_digit];
    end else begin
      seg_next = stopwatch_pkg::SEG_BLANK;  // Not a BCD value
    end
  end

  // Index 0 is the leftmost digit, on anode bit 3
  assign anode_hot  = {1'b1, {(stopwatch_pkg::NUM_DIGITS-1){1'b0}}} >> scan_idx;
  assign anode_next = ~anode_hot;

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      anode   <= stopwatch_pkg::ANODE_IDLE;
      segment <= stopwatch_pkg::SEG_BLANK;
    end else begin
      anode   <= anode_next;
      segment <= seg_next;
    end
  end

endmodule

// ==== source/stopwatch_top.sv ====
`timescale 1ns/1ps

module stopwatch_top (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  up,
  input  logic                  clr,
  input  logic                  enable,
  output stopwatch_pkg::anode_t anode,
  output stopwatch_pkg::seg_t   segment
);

  logic                 down_mode;
  logic                 load_down;
  logic                 tick;
  stopwatch_pkg::time_t up_time;
  stopwatch_pkg::time_t down_time;

  //////////////////////////////////////////////////////////////////////
  // Decode, switch conditioning
  //////////////////////////////////////////////////////////////////////

  mode_decode mode_decode_uut (
    .clock     (clock    ),
    .rst       (rst      ),
    .up        (up       ),
    .down_mode (down_mode),
    .load_down (load_down)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute, prescaler and counter chains
  //////////////////////////////////////////////////////////////////////

  tenth_tick_gen tenth_tick_gen_uut (
    .clock  (clock ),
    .rst    (rst   ),
    .clr    (clr   ),
    .enable (enable),
    .tick   (tick  )
  );

  stopwatch_core stopwatch_core_uut (
    .clock     (clock    ),
    .rst       (rst      ),
    .clr       (clr      ),
    .tick      (tick     ),
    .load_down (load_down),
    .up_time   (up_time  ),
    .down_time (down_time)
  );

  //////////////////////////////////////////////////////////////////////
  // Result, display scan
  //////////////////////////////////////////////////////////////////////

  display_scan display_scan_uut (
    .clock     (clock    ),
    .rst       (rst      ),
    .down_mode (down_mode),  // Scan keeps running while frozen
    .up_time   (up_time  ),
    .down_time (down_time),
    .anode     (anode    ),
    .segment   (segment  )
  );

endmodule

// ==== verification/stopwatch_tb.sv ====
`timescale 1ns/1ps

module stopwatch_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 16;
  localparam int WRAP_TENTHS  = 10 * 60 * 10;  // 9:59.9 rolls over to 0:00.0

  // Cycle budgets that the watchdog adds up
  localparam int RESET_BUDGET    = 40;
  localparam int UP_BUDGET       = 6500;
  localparam int FREEZE_BUDGET   = 300;
  localparam int DOWN_BUDGET     = 2800;
  localparam int WRAP_BUDGET     = 60;
  localparam int RETURN_BUDGET   = 800;
  localparam int TOTAL_CYCLES    = RESET_BUDGET + UP_BUDGET + FREEZE_BUDGET +
                                   DOWN_BUDGET + WRAP_BUDGET + RETURN_BUDGET;

  logic                  clock;
  logic                  rst;
  logic                  up;
  logic                  clr;
  logic                  enable;
  stopwatch_pkg::anode_t anode;
  stopwatch_pkg::seg_t   segment;

  logic [15:0] lfsr_state = 16'd66;
  int          up_model;         // Up chain in tenths
  int          down_model;       // Down chain in tenths
  logic        down_mode_model;  // Which chain the display shows

  stopwatch_top uut (
    .clock   (clock  ),
    .rst     (rst    ),
    .up      (up     ),
    .clr     (clr    ),
    .enable  (enable ),
    .anode   (anode  ),
    .segment (segment)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", TOTAL_CYCLES * 2);
    $display("TEST FAIL");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Inputs change this long after the edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  function automatic stopwatch_pkg::time_t digits_of(input int tenths);
    stopwatch_pkg::time_t t;
    t[0] = stopwatch_pkg::digit_t'((tenths / 600) % 10);  // Minutes
    t[1] = stopwatch_pkg::digit_t'((tenths / 100) % 6);   // Tens of seconds
    t[2] = stopwatch_pkg::digit_t'((tenths / 10) % 10);
    t[3] = stopwatch_pkg::digit_t'(tenths % 10);
    return t;
  endfunction

  // Digit k lights with anode bit 3-k pulled low
  function automatic stopwatch_pkg::anode_t anode_for(input logic [1:0] k);
    stopwatch_pkg::anode_t a;
    a = '1;
    a[2'd3 - k] = 1'b0;
    return a;
  endfunction

  task automatic fail_now();
    $display("TEST FAIL");
    $fatal(1, "stopping at first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_digit(input stopwatch_pkg::digit_t got,
                             input stopwatch_pkg::digit_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_anode(input stopwatch_pkg::anode_t got,
                             input stopwatch_pkg::anode_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %b expected %b", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_segment(input stopwatch_pkg::seg_t got,
                               input stopwatch_pkg::seg_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %b expected %b", $time, what, got, exp);
      fail_now();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Display decoding
  //////////////////////////////////////////////////////////////////////

  task automatic find_index(input stopwatch_pkg::anode_t a, output logic [1:0] idx);
    logic       found;
    logic [2:0] k;
    found = 1'b0;
    idx   = '0;
    for (k = 3'd0; k < 3'd4; k = k + 3'd1) begin
      if (a == anode_for(k[1:0])) begin
        idx   = k[1:0];
        found = 1'b1;
      end
    end
    if (!found) begin
      $display("Anode pattern %b at time %0t does not select a single digit", a, $time);
      fail_now();
    end
  endtask

  // Inverse of the segment table
  task automatic decode_segment(input stopwatch_pkg::seg_t s,
                                output stopwatch_pkg::digit_t value);
    logic       found;
    logic [3:0] v;
    found = 1'b0;
    value = '0;
    for (v = 4'd0; v < stopwatch_pkg::digit_t'(stopwatch_pkg::SEG_ENTRIES); v = v + 4'd1) begin
      if (s == stopwatch_pkg::SEG_TABLE[v]) begin
        value = v;
        found = 1'b1;
      end
    end
    if (!found) begin
      $display("Segment pattern %b at time %0t is not a digit", s, $time);
      fail_now();
    end
  endtask

  task automatic read_display(input string what);
    stopwatch_pkg::time_t  expected;
    stopwatch_pkg::digit_t value;
    logic [1:0]            idx;
    logic [1:0]            prev_idx;
    logic                  have_prev;
    enable = 1'b0;
    step_cycles(2);  // Let the output registers catch up
    if (down_mode_model) expected = digits_of(down_model);
    else                 expected = digits_of(up_model);
    have_prev = 1'b0;
    prev_idx  = '0;
    repeat (stopwatch_pkg::NUM_DIGITS) begin
      step_cycles(1);
      find_index(anode, idx);
      if (have_prev) check_anode(anode, anode_for(prev_idx + 2'd1), {what, ", scan order"});
      decode_segment(segment, value);
      check_digit(value, expected[idx], $sformatf("%s, digit %0d", what, idx));
      prev_idx  = idx;
      have_prev = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus with model updates
  //////////////////////////////////////////////////////////////////////

  // Whole ticks only so the prescaler sits at zero between calls
  task automatic run_ticks(input int n);
    enable = 1'b1;
    step_cycles(n * stopwatch_pkg::TICK_DIVIDE);
    enable = 1'b0;
    up_model   = (up_model + n) % WRAP_TENTHS;
    down_model = (down_model + WRAP_TENTHS - (n % WRAP_TENTHS)) % WRAP_TENTHS;
  endtask

  task automatic do_clear();
    clr = 1'b1;
    step_cycles(1);
    clr = 1'b0;
    up_model   = 0;
    down_model = 0;
  endtask

  task automatic set_up_switch(input logic level);
    logic rising;
    rising = level & ~up;
    up     = level;
    step_cycles(stopwatch_pkg::SYNC_STAGES + 1);
    if (rising) down_model = up_model;  // Snapshot on the rising edge
    down_mode_model = level;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    step_cycles(RESET_CYCLES);
    rst = 1'b0;
    check_anode(anode, stopwatch_pkg::ANODE_IDLE, "anode right after reset");
    check_segment(segment, stopwatch_pkg::SEG_BLANK, "segment right after reset");
    read_display("after reset");
  endtask

  task automatic count_up_chunks();
    int r;
    do_clear();
    draw_bits(3, r);
    run_ticks(90 + r);
    read_display("up count below 0:10.0");
    draw_bits(4, r);
    run_ticks(10 + r);     // Past 0:09.9
    read_display("up count past 0:09.9");
    repeat (3) begin
      draw_bits(7, r);
      run_ticks(1 + r);
      read_display("up count random chunk");
    end
    if (up_model < 610) begin
      draw_bits(3, r);
      run_ticks(610 - up_model + r);  // Past 0:59.9
      read_display("up count past 0:59.9");
    end
  endtask

  task automatic freeze_then_clear();
    read_display("before freeze");
    step_cycles(200);
    read_display("after freeze");
    do_clear();
    read_display("after clear");
  endtask

  task automatic load_and_count_down();
    int r;
    do_clear();
    draw_bits(6, r);
    run_ticks(50 + r);
    set_up_switch(1'b1);
    read_display("down chain just loaded");
    draw_bits(7, r);
    run_ticks(20 + r);
    read_display("count down");
  endtask

  task automatic wrap_down_chain();
    set_up_switch(1'b0);
    do_clear();
    set_up_switch(1'b1);   // Loads 0:00.0
    run_ticks(1);
    read_display("down wrap to 9:59.9");
  endtask

  task automatic return_to_up();
    int r;
    draw_bits(6, r);
    run_ticks(1 + r);
    read_display("down chain before return");
    set_up_switch(1'b0);
    read_display("return to up");
  endtask

  initial begin
    rst             = 1'b1;
    up              = 1'b0;
    clr             = 1'b0;
    enable          = 1'b0;
    up_model        = 0;
    down_model      = 0;
    down_mode_model = 1'b0;
    reset_values();
    count_up_chunks();
    freeze_then_clear();
    load_and_count_down();
    wrap_down_chain();
    return_to_up();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== all.f ====
source/stopwatch_pkg.sv
source/mode_decode.sv
source/tenth_tick_gen.sv
source/stopwatch_core.sv
source/display_scan.sv
source/stopwatch_top.sv
verification/stopwatch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --binary --timing
LINT_FLAGS := --lint-only --timing
TOP        := stopwatch_tb
RTL_TOP    := stopwatch_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
